// File: hw/cpu_pkg.sv
package cpu_pkg;

  // ==============================
  // Sequencer and micro-op types
  // ==============================
  typedef enum logic [1:0] {
    T1,
    T2,
    T3,
    T4
  } t_phase_t;

  typedef enum logic [2:0] {
    ADDR_PC,
    ADDR_SP,
    ADDR_HL,
    ADDR_WZ,
    ADDR_NONE
  } addr_src_t;

  typedef enum logic [1:0] {
    BUS_NONE,
    BUS_READ,
    BUS_WRITE
  } bus_op_t;

  // Byte register loaded by a read or driven onto a write
  typedef enum logic [2:0] {
    A,
    B,
    H,
    L,
    W,
    Z,
    PCH,
    PCL
  } reg_sel_t;

  typedef enum logic [1:0] {
    ALU_NONE,
    ALU_INC,
    ALU_DEC,
    ALU_MOV
  } alu_op_t;

  // ALU target; PC only takes a vector, SP only steps
  typedef enum logic [1:0] {
    DST_A,
    DST_B,
    DST_PC,
    DST_SP
  } alu_dst_t;

  typedef enum logic [1:0] {
    IDU_NONE,
    IDU_INC,
    IDU_DEC
  } idu_op_t;

  typedef enum logic [2:0] {
    MISC_NONE,
    MISC_COND_NZ,
    MISC_JUMP_WZ,
    MISC_HALT,
    MISC_EI,
    MISC_DI,
    MISC_RETI
  } misc_op_t;

  localparam int MAX_CYCLES = 5;

  // One machine cycle; idu_dst set sends the IDU result to PC
  typedef struct packed {
    addr_src_t  addr_src;
    bus_op_t    bus_op;
    reg_sel_t   data_reg;
    idu_op_t    idu_op;
    logic       idu_dst;
    alu_op_t    alu_op;
    alu_dst_t   alu_dst;
    logic [2:0] alu_src;
    misc_op_t   misc_op;
  } micro_cycle_t;

  typedef struct packed {
    micro_cycle_t [MAX_CYCLES-1:0] cycles;
    logic [2:0]                    num_cycles;
  } control_word_t;

  // ==============================
  // Register file and bus
  // ==============================
  typedef union packed {
    logic [15:0] word;
    struct packed {
      logic [7:0] hi;
      logic [7:0] lo;
    } bytes;
  } reg_pair_u;

  typedef struct packed {
    reg_pair_u  pc;
    reg_pair_u  sp;
    reg_pair_u  hl;
    reg_pair_u  wz;
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] ir;
    logic       z;
    logic       n;
    logic       ime;
  } cpu_regs_t;

  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        read_en;
    logic        write_en;
  } bus_req_t;

  typedef struct packed {
    logic vblank;
    logic stat;
    logic timer;
    logic serial;
    logic joypad;
  } irq_req_t;

  // Memory map
  localparam logic [15:0] IF_ADDR   = 16'hFF0F;
  localparam logic [15:0] IE_ADDR   = 16'hFFFF;
  localparam int          WRAM_DEPTH = 1024;
  localparam logic [15:0] HRAM_BASE = 16'hFF80;
  localparam logic [15:0] RESET_SP  = 16'hFFFE;

  localparam logic [15:0] IRQ_VECTOR_BASE = 16'h0040;
  localparam logic [15:0] IRQ_VECTOR_STEP = 16'd8;

  // Common micro-cycles
  localparam micro_cycle_t MC_IDLE = '{
    addr_src: ADDR_NONE, bus_op: BUS_NONE, data_reg: A, idu_op: IDU_NONE,
    idu_dst: 1'b0, alu_op: ALU_NONE, alu_dst: DST_A, alu_src: 3'd0,
    misc_op: MISC_NONE
  };
  localparam micro_cycle_t MC_FETCH = '{
    addr_src: ADDR_PC, bus_op: BUS_READ, data_reg: A, idu_op: IDU_INC,
    idu_dst: 1'b0, alu_op: ALU_NONE, alu_dst: DST_A, alu_src: 3'd0,
    misc_op: MISC_NONE
  };
  localparam control_word_t FETCH_WORD = '{
    cycles: {{(MAX_CYCLES-1){MC_IDLE}}, MC_FETCH},
    num_cycles: 3'd1
  };

endpackage

// File: hw/control_rom.sv
`timescale 1ns/1ps

module control_rom import cpu_pkg::*; (
  input  logic [7:0]    opcode,
  input  logic          irq_mode,
  input  logic [2:0]    irq_index,
  output control_word_t word
);

  micro_cycle_t c0, c1, c2, c3;

  // Last cycle of every word is the opcode fetch into IR
  always_comb begin
    word = FETCH_WORD;
    c0 = MC_IDLE;
    c1 = MC_IDLE;
    c2 = MC_IDLE;
    c3 = MC_IDLE;

    if (irq_mode) begin
      // Dispatch: step PC back over the discarded opcode, push, jump
      c0.addr_src = ADDR_PC;
      c0.idu_op   = IDU_DEC;
      c0.alu_op   = ALU_DEC;
      c0.alu_dst  = DST_SP;
      c1.addr_src = ADDR_SP;
      c1.bus_op   = BUS_WRITE;
      c1.data_reg = PCH;
      c1.idu_op   = IDU_DEC;
      c2.addr_src = ADDR_SP;
      c2.bus_op   = BUS_WRITE;
      c2.data_reg = PCL;
      c3.alu_op   = ALU_MOV;
      c3.alu_dst  = DST_PC;
      c3.alu_src  = irq_index;
      word = '{cycles: {MC_FETCH, c3, c2, c1, c0}, num_cycles: 3'd5};
    end else begin
      unique case (opcode)
        8'h3E, 8'h06: begin
          // LD A,d8 / LD B,d8
          c0 = MC_FETCH;
          c0.data_reg = (opcode == 8'h3E) ? A : B;
          word = '{cycles: {{3{MC_IDLE}}, MC_FETCH, c0}, num_cycles: 3'd2};
        end
        8'h21: begin
          // LD HL,d16
          c0 = MC_FETCH;
          c0.data_reg = L;
          c1 = MC_FETCH;
          c1.data_reg = H;
          word = '{cycles: {{2{MC_IDLE}}, MC_FETCH, c1, c0}, num_cycles: 3'd3};
        end
        8'h77, 8'h7E: begin
          // LD (HL),A / LD A,(HL)
          c0.addr_src = ADDR_HL;
          c0.bus_op   = (opcode == 8'h77) ? BUS_WRITE : BUS_READ;
          c0.data_reg = A;
          word = '{cycles: {{3{MC_IDLE}}, MC_FETCH, c0}, num_cycles: 3'd2};
        end
        8'h3C, 8'h05: begin
          // INC A / DEC B overlap with the fetch
          c0 = MC_FETCH;
          c0.alu_op  = (opcode == 8'h3C) ? ALU_INC : ALU_DEC;
          c0.alu_dst = (opcode == 8'h3C) ? DST_A : DST_B;
          word = '{cycles: {{4{MC_IDLE}}, c0}, num_cycles: 3'd1};
        end
        8'hC3, 8'hC2: begin
          // JP a16 / JP NZ,a16; untaken skips to the fetch
          c0 = MC_FETCH;
          c0.data_reg = Z;
          c1 = MC_FETCH;
          c1.data_reg = W;
          if (opcode == 8'hC2) c1.misc_op = MISC_COND_NZ;
          c2.misc_op = MISC_JUMP_WZ;
          word = '{cycles: {MC_IDLE, MC_FETCH, c2, c1, c0}, num_cycles: 3'd4};
        end
        8'h76, 8'hFB, 8'hF3: begin
          c0 = MC_FETCH;
          c0.misc_op = (opcode == 8'h76) ? MISC_HALT :
                       (opcode == 8'hFB) ? MISC_EI : MISC_DI;
          word = '{cycles: {{4{MC_IDLE}}, c0}, num_cycles: 3'd1};
        end
        8'hD9: begin
          // RETI pops into WZ and fetches there
          c0.addr_src = ADDR_SP;
          c0.bus_op   = BUS_READ;
          c0.data_reg = Z;
          c0.idu_op   = IDU_INC;
          c1 = c0;
          c1.data_reg = W;
          c2.misc_op  = MISC_RETI;
          c3 = MC_FETCH;
          c3.addr_src = ADDR_WZ;
          c3.idu_dst  = 1'b1;
          word = '{cycles: {MC_IDLE, c3, c2, c1, c0}, num_cycles: 3'd4};
        end
        default: word = FETCH_WORD;
      endcase
    end
  end

endmodule

// File: hw/interrupt_ctrl.sv
`timescale 1ns/1ps

module interrupt_ctrl import cpu_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  bus_req_t   bus,
  input  irq_req_t   irq,
  input  logic       ack,
  output logic       pending,
  output logic [2:0] irq_index,
  output logic [7:0] reg_rdata
);

  logic [4:0] if_q;
  logic [7:0] ie_q;
  logic [4:0] req_bits;
  logic [4:0] active;

  // Bit 0 is vblank, the highest priority
  assign req_bits = {irq.joypad, irq.serial, irq.timer, irq.stat, irq.vblank};
  assign active   = if_q & ie_q[4:0];
  assign pending  = |active;

  always_comb begin
    irq_index = 3'd0;
    for (int i = 4; i >= 0; i--) begin
      if (active[i]) irq_index = 3'(i);
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      if_q <= '0;
      ie_q <= '0;
    end else begin
      if (bus.write_en && bus.addr == IF_ADDR) if_q <= bus.wdata[4:0];
      if (bus.write_en && bus.addr == IE_ADDR) ie_q <= bus.wdata;
      if (ack) if_q[irq_index] <= 1'b0;
      // A new request beats a write or ack on the same bit
      for (int i = 0; i < 5; i++) begin
        if (req_bits[i]) if_q[i] <= 1'b1;
      end
    end
  end

  // Unused IF bits read back as ones
  always_comb begin
    reg_rdata = 8'h00;
    if (bus.addr == IF_ADDR) begin
      reg_rdata = {3'b111, if_q};
    end else if (bus.addr == IE_ADDR) begin
      reg_rdata = ie_q;
    end
  end

endmodule

// File: hw/cpu_core.sv
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] rdata,
  input  irq_req_t   irq,
  output bus_req_t   bus,
  output t_phase_t   t_phase,
  output logic       instr_boundary,
  output logic [7:0] irq_rdata
);

  cpu_regs_t     regs;
  control_word_t control_word;
  control_word_t rom_word;
  micro_cycle_t  mc;
  logic [2:0]    cycle;
  logic          halted;
  logic          pending;
  logic [2:0]    irq_index;
  logic          at_last;
  logic          cond_fail;
  logic          finish;
  logic          take_irq;
  logic          halt_now;
  logic [15:0]   pair_val;
  logic [15:0]   idu_val;
  logic [7:0]    alu_in;
  logic [7:0]    alu_out;

  control_rom u_rom (
    .opcode   (regs.ir),
    .irq_mode (take_irq),
    .irq_index(irq_index),
    .word     (rom_word)
  );

  interrupt_ctrl u_irq (
    .clk      (clk),
    .reset    (reset),
    .bus      (bus),
    .irq      (irq),
    .ack      (take_irq),
    .pending  (pending),
    .irq_index(irq_index),
    .reg_rdata(irq_rdata)
  );

  // ==============================
  // Step decisions
  // ==============================
  assign mc        = control_word.cycles[cycle];
  assign at_last   = ({1'b0, cycle} + 4'd1) >= {1'b0, control_word.num_cycles};
  assign cond_fail = (mc.misc_op == MISC_COND_NZ) && regs.z;
  assign finish    = halted ? pending : (t_phase == T4 && at_last && !cond_fail);
  // DI takes effect before the boundary check
  assign take_irq  = finish && regs.ime && pending && !(mc.misc_op == MISC_DI && !halted);
  assign halt_now  = !halted && finish && mc.misc_op == MISC_HALT && !take_irq;

  always_comb begin
    unique case (mc.addr_src)
      ADDR_PC: pair_val = regs.pc.word;
      ADDR_SP: pair_val = regs.sp.word;
      ADDR_HL: pair_val = regs.hl.word;
      ADDR_WZ: pair_val = regs.wz.word;
      default: pair_val = 16'h0000;
    endcase
    idu_val = (mc.idu_op == IDU_DEC) ? pair_val - 16'd1 : pair_val + 16'd1;
    alu_in  = (mc.alu_dst == DST_B) ? regs.b : regs.a;
    alu_out = (mc.alu_op == ALU_DEC) ? alu_in - 8'd1 : alu_in + 8'd1;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regs           <= '0;
      regs.sp.word   <= RESET_SP;
      bus            <= '0;
      t_phase        <= T1;
      cycle          <= '0;
      control_word   <= FETCH_WORD;
      halted         <= 1'b0;
      instr_boundary <= 1'b0;
    end else begin
      instr_boundary <= 1'b0;
      if (halted) begin
        // Frozen in T4 until something enabled is pending
        if (pending) begin
          halted       <= 1'b0;
          t_phase      <= T1;
          cycle        <= '0;
          control_word <= rom_word;
          if (take_irq) regs.ime <= 1'b0;
          else instr_boundary <= 1'b1;
        end
      end else begin
        unique case (t_phase)
          T1: begin
            bus.addr <= pair_val;
            t_phase  <= T2;
          end
          T2: begin
            bus.read_en  <= (mc.bus_op == BUS_READ);
            bus.write_en <= (mc.bus_op == BUS_WRITE);
            unique case (mc.data_reg)
              A:       bus.wdata <= regs.a;
              B:       bus.wdata <= regs.b;
              H:       bus.wdata <= regs.hl.bytes.hi;
              L:       bus.wdata <= regs.hl.bytes.lo;
              W:       bus.wdata <= regs.wz.bytes.hi;
              Z:       bus.wdata <= regs.wz.bytes.lo;
              PCH:     bus.wdata <= regs.pc.bytes.hi;
              default: bus.wdata <= regs.pc.bytes.lo;
            endcase
            t_phase <= T3;
          end
          T3: begin
            if (mc.bus_op == BUS_READ) begin
              if (at_last) begin
                regs.ir <= rdata;
              end else begin
                unique case (mc.data_reg)
                  A:       regs.a <= rdata;
                  B:       regs.b <= rdata;
                  H:       regs.hl.bytes.hi <= rdata;
                  L:       regs.hl.bytes.lo <= rdata;
                  W:       regs.wz.bytes.hi <= rdata;
                  Z:       regs.wz.bytes.lo <= rdata;
                  PCH:     regs.pc.bytes.hi <= rdata;
                  default: regs.pc.bytes.lo <= rdata;
                endcase
              end
            end
            t_phase <= T4;
          end
          default: begin
            bus.read_en  <= 1'b0;
            bus.write_en <= 1'b0;

            // IDU writes back to its source pair unless sent to PC
            if (mc.idu_op != IDU_NONE) begin
              if (mc.idu_dst) regs.pc.word <= idu_val;
              else begin
                unique case (mc.addr_src)
                  ADDR_PC: regs.pc.word <= idu_val;
                  ADDR_SP: regs.sp.word <= idu_val;
                  ADDR_HL: regs.hl.word <= idu_val;
                  ADDR_WZ: regs.wz.word <= idu_val;
                  default: ;
                endcase
              end
            end

            if (mc.alu_op == ALU_MOV && mc.alu_dst == DST_PC) begin
              regs.pc.word <= IRQ_VECTOR_BASE + 16'(mc.alu_src) * IRQ_VECTOR_STEP;
            end else if (mc.alu_op != ALU_NONE && mc.alu_dst == DST_SP) begin
              regs.sp.word <= (mc.alu_op == ALU_DEC) ? regs.sp.word - 16'd1
                                                     : regs.sp.word + 16'd1;
            end else if (mc.alu_op == ALU_INC || mc.alu_op == ALU_DEC) begin
              if (mc.alu_dst == DST_B) regs.b <= alu_out;
              else regs.a <= alu_out;
              regs.z <= (alu_out == 8'h00);
              regs.n <= (mc.alu_op == ALU_DEC);
            end

            unique case (mc.misc_op)
              MISC_JUMP_WZ:       regs.pc.word <= regs.wz.word;
              MISC_EI, MISC_RETI: regs.ime <= 1'b1;
              MISC_DI:            regs.ime <= 1'b0;
              default: ;
            endcase

            if (cond_fail) begin
              cycle   <= control_word.num_cycles - 3'd1;
              t_phase <= T1;
            end else if (at_last) begin
              cycle        <= '0;
              control_word <= rom_word;
              if (halt_now) begin
                halted  <= 1'b1;
                t_phase <= T4;
              end else begin
                t_phase        <= T1;
                instr_boundary <= !take_irq;
              end
              if (take_irq) regs.ime <= 1'b0;
            end else begin
              cycle   <= cycle + 3'd1;
              t_phase <= T1;
            end
          end
        endcase
      end
    end
  end

endmodule

// File: hw/mem_map.sv
`timescale 1ns/1ps

module mem_map import cpu_pkg::*; (
  input  logic       clk,
  input  bus_req_t   bus,
  input  logic [7:0] irq_rdata,
  output logic [7:0] rdata
);

  localparam int HRAM_DEPTH = 127;

  logic [7:0] wram [WRAM_DEPTH];
  logic [7:0] hram [HRAM_DEPTH];

  logic in_wram;
  logic in_hram;
  logic in_irq;

  assign in_wram = bus.addr < 16'(WRAM_DEPTH);
  // High RAM stops just below IE
  assign in_hram = bus.addr >= HRAM_BASE && bus.addr != IE_ADDR;
  assign in_irq  = bus.addr == IF_ADDR || bus.addr == IE_ADDR;

  always_ff @(posedge clk) begin
    if (bus.write_en) begin
      if (in_wram) wram[bus.addr[9:0]] <= bus.wdata;
      if (in_hram) hram[bus.addr[6:0]] <= bus.wdata;
    end
  end

  always_comb begin
    if (in_wram) begin
      rdata = wram[bus.addr[9:0]];
    end else if (in_hram) begin
      rdata = hram[bus.addr[6:0]];
    end else if (in_irq) begin
      rdata = irq_rdata;
    end else begin
      rdata = 8'hFF;
    end
  end

endmodule

// File: hw/gb_soc.sv
`timescale 1ns/1ps

module gb_soc import cpu_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  irq_req_t irq,
  output bus_req_t bus,
  output t_phase_t t_phase,
  output logic     instr_boundary
);

  logic [7:0] rdata;
  logic [7:0] irq_rdata;

  cpu_core u_core (
    .clk           (clk),
    .reset         (reset),
    .rdata         (rdata),
    .irq           (irq),
    .bus           (bus),
    .t_phase       (t_phase),
    .instr_boundary(instr_boundary),
    .irq_rdata     (irq_rdata)
  );

  mem_map u_mem (
    .clk      (clk),
    .bus      (bus),
    .irq_rdata(irq_rdata),
    .rdata    (rdata)
  );

endmodule

// File: dv/gb_soc_asserts.sv
`timescale 1ns/1ps

module gb_soc_asserts import cpu_pkg::*; (
  input logic     clk,
  input logic     reset,
  input irq_req_t irq,
  input bus_req_t bus,
  input t_phase_t t_phase,
  input logic     instr_boundary
);

  localparam logic [15:0] LOOP_ADDR = 16'h0100;
  localparam logic [15:0] PUSH_HI   = 16'hFFFD;
  localparam logic [15:0] PUSH_LO   = 16'hFFFC;
  // Opcode after the first HALT is where both dispatches return
  localparam logic [15:0] RET_PC    = 16'h0017;
  localparam int          LOOP_RUNS = 5;

  int         error_count = 0;
  t_phase_t   prev_phase;
  logic       wr_start;
  logic       rd_start;
  logic       strobe;
  logic       in_halt;
  logic       in_dispatch;
  logic [3:0] loop_writes;
  logic [1:0] dispatch_count;

  // A transfer starts in T3, the first clock with its strobe high
  assign wr_start = bus.write_en && t_phase == T3;
  assign rd_start = bus.read_en && t_phase == T3;
  assign strobe   = bus.read_en || bus.write_en;
  assign in_halt  = prev_phase == T4 && t_phase == T4;

  // Count up with A, then one more write of the final count
  function automatic logic [7:0] loop_value(input logic [3:0] n);
    return (n < LOOP_RUNS) ? 8'(n + 4'd1) : 8'(LOOP_RUNS);
  endfunction

  // vblank is served first, timer two vectors further up
  function automatic logic [15:0] vector_addr(input logic [1:0] n);
    return (n == 2'd1) ? 16'h0040 : 16'h0050;
  endfunction

  function automatic void count_failure(input string msg);
    error_count++;
    $error("%s", msg);
  endfunction

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      prev_phase     <= T4;
      in_dispatch    <= 1'b0;
      loop_writes    <= '0;
      dispatch_count <= '0;
    end else begin
      prev_phase <= t_phase;
      if (wr_start && bus.addr == LOOP_ADDR) loop_writes <= loop_writes + 4'd1;
      if (wr_start && bus.addr == PUSH_HI) in_dispatch <= 1'b1;
      else if (rd_start) in_dispatch <= 1'b0;
      if (wr_start && bus.addr == PUSH_LO) dispatch_count <= dispatch_count + 2'd1;
    end
  end

  // ==============================
  // Sequencer and strobes
  // ==============================
  a_reset_idle: assert property (@(posedge clk)
    reset |-> t_phase == T1 && !strobe)
    else count_failure("Core is not idle in T1 while reset is held");

  a_phase_step: assert property (@(posedge clk) disable iff (reset)
    prev_phase != T4 |-> t_phase == t_phase_t'(prev_phase + 2'd1))
    else count_failure($sformatf("FAILED t_phase: got %h after %h",
                                 $sampled(t_phase), $sampled(prev_phase)));

  a_phase_wrap: assert property (@(posedge clk) disable iff (reset)
    prev_phase == T4 |-> t_phase inside {T1, T4})
    else count_failure($sformatf("FAILED t_phase: got %h after T4", $sampled(t_phase)));

  a_strobe_excl: assert property (@(posedge clk) disable iff (reset)
    !(bus.read_en && bus.write_en))
    else count_failure("Read and write strobes are high together");

  a_strobe_phase: assert property (@(posedge clk) disable iff (reset)
    strobe |-> t_phase inside {T3, T4})
    else count_failure($sformatf("FAILED t_phase under a strobe: got %h", $sampled(t_phase)));

  a_addr_stable: assert property (@(posedge clk) disable iff (reset)
    strobe ##1 strobe |-> $stable(bus.addr))
    else count_failure($sformatf("FAILED bus.addr moved under a strobe: now %h",
                                 $sampled(bus.addr)));

  // ==============================
  // HALT and interrupts
  // ==============================
  a_halt_quiet: assert property (@(posedge clk) disable iff (reset)
    in_halt |-> !strobe)
    else count_failure("A strobe rose while the core is halted");

  // Every request in this test targets an enabled source
  a_halt_wake: assert property (@(posedge clk) disable iff (reset)
    (irq != '0) && in_halt |-> ##2 t_phase == T1)
    else count_failure("Halted core did not wake on an enabled request");

  a_loop_data: assert property (@(posedge clk) disable iff (reset)
    wr_start && bus.addr == LOOP_ADDR |-> bus.wdata == loop_value(loop_writes))
    else count_failure($sformatf("FAILED bus.wdata at 0100: got %h, expected %h",
                                 $sampled(bus.wdata), loop_value($sampled(loop_writes))));

  a_loop_extra: assert property (@(posedge clk) disable iff (reset)
    wr_start && bus.addr == LOOP_ADDR |-> loop_writes < 4'd6)
    else count_failure("More than six writes reached address 0100");

  a_loop_done: assert property (@(posedge clk) disable iff (reset)
    wr_start && bus.addr == PUSH_HI |-> loop_writes == 4'd6)
    else count_failure($sformatf("FAILED writes to 0100 before dispatch: got %h, expected %h",
                                 $sampled(loop_writes), 4'd6));

  a_push_hi: assert property (@(posedge clk) disable iff (reset)
    wr_start && bus.addr == PUSH_HI |-> bus.wdata == RET_PC[15:8])
    else count_failure($sformatf("FAILED bus.wdata at FFFD: got %h, expected %h",
                                 $sampled(bus.wdata), RET_PC[15:8]));

  a_push_lo: assert property (@(posedge clk) disable iff (reset)
    wr_start && bus.addr == PUSH_LO |-> bus.wdata == RET_PC[7:0])
    else count_failure($sformatf("FAILED bus.wdata at FFFC: got %h, expected %h",
                                 $sampled(bus.wdata), RET_PC[7:0]));

  a_push_order: assert property (@(posedge clk) disable iff (reset)
    wr_start && bus.addr == PUSH_LO |-> in_dispatch && dispatch_count < 2'd2)
    else count_failure("Low byte push came without the high byte or after two dispatches");

  a_vector: assert property (@(posedge clk) disable iff (reset)
    rd_start && in_dispatch |-> bus.addr == vector_addr(dispatch_count))
    else count_failure($sformatf("FAILED bus.addr of vector fetch: got %h, expected %h",
                                 $sampled(bus.addr), vector_addr($sampled(dispatch_count))));

  // Both dispatches are over before the joypad request arrives
  a_dispatch_done: assert property (@(posedge clk) disable iff (reset)
    irq.joypad |-> dispatch_count == 2'd2)
    else count_failure($sformatf("FAILED dispatch_count at joypad request: got %h, expected %h",
                                 $sampled(dispatch_count), 2'd2));

  // ==============================
  // Instruction boundary
  // ==============================
  a_boundary_step: assert property (@(posedge clk) disable iff (reset)
    instr_boundary |-> t_phase == T1 && prev_phase == T4)
    else count_failure("instr_boundary pulsed outside a T4 to T1 step");

  a_boundary_dispatch: assert property (@(posedge clk) disable iff (reset)
    in_dispatch |-> !instr_boundary)
    else count_failure("instr_boundary pulsed in the middle of a dispatch");

  // End of the dummy cycle shows two clocks before the high byte push starts
  a_boundary_dummy: assert property (@(posedge clk) disable iff (reset)
    wr_start && bus.addr == PUSH_HI |-> !$past(instr_boundary, 2))
    else count_failure("instr_boundary pulsed after the dummy cycle of a dispatch");

endmodule

bind gb_soc gb_soc_asserts u_asserts (
  .clk           (clk),
  .reset         (reset),
  .irq           (irq),
  .bus           (bus),
  .t_phase       (t_phase),
  .instr_boundary(instr_boundary)
);

// File: dv/tb_top.sv
`timescale 1ns/1ps

module tb_top import cpu_pkg::*; ();

  localparam int CLK_PERIOD  = 8;
  localparam int DRIVE_DELAY = 1;
  localparam int MCYCLE_NS   = 4 * CLK_PERIOD;
  // Loop, dispatch, wake without IME, final park
  localparam int NUM_PHASES  = 4;
  localparam int WATCHDOG_NS = 200 * MCYCLE_NS * NUM_PHASES;

  logic     clk;
  logic     reset;
  irq_req_t irq;
  bus_req_t bus;
  t_phase_t t_phase;
  logic     instr_boundary;

  gb_soc dut (
    .clk           (clk),
    .reset         (reset),
    .irq           (irq),
    .bus           (bus),
    .t_phase       (t_phase),
    .instr_boundary(instr_boundary)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic int random_gap();
    return 3 + ($urandom % 16);
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
    #(DRIVE_DELAY);
  endtask

  task automatic wait_halt_state(input logic state);
    while (dut.u_core.halted !== state) begin
      @(posedge clk);
      #(DRIVE_DELAY);
    end
  endtask

  // One-clock request pulse
  task automatic pulse_irq(input irq_req_t req);
    irq = req;
    @(posedge clk);
    #(DRIVE_DELAY);
    irq = '0;
  endtask

  initial begin
    irq_req_t req;
    void'($urandom(32'hfa03_fe67));
    clk   = 1'b0;
    reset = 1'b0;
    irq   = '0;
    $readmemh("dv/program.hex", dut.u_mem.wram);
    #(DRIVE_DELAY);
    reset = 1'b1;
    repeat (16) @(posedge clk);
    #(DRIVE_DELAY);
    reset = 1'b0;

    // vblank and timer together while halted with IME set
    wait_halt_state(1'b1);
    idle_cycles(random_gap());
    req        = '0;
    req.vblank = 1'b1;
    req.timer  = 1'b1;
    pulse_irq(req);
    wait_halt_state(1'b0);

    // Second HALT runs after DI, joypad only wakes it
    wait_halt_state(1'b1);
    idle_cycles(random_gap());
    req        = '0;
    req.joypad = 1'b1;
    pulse_irq(req);
    wait_halt_state(1'b0);

    // Program clears IF, restores IE and parks
    wait_halt_state(1'b1);
    idle_cycles(random_gap());

    $display("Assertion failures: %0d", dut.u_asserts.error_count);
    if (dut.u_asserts.error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the program did not reach its final halt within %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: vlog.f
hw/cpu_pkg.sv
hw/control_rom.sv
hw/interrupt_ctrl.sv
hw/cpu_core.sv
hw/mem_map.sv
hw/gb_soc.sv
dv/gb_soc_asserts.sv
dv/tb_top.sv

// File: dv/program.hex
// Work RAM image: hex bytes in address order, an @ line moves to a new address
// Counting loop writes 01..05 to 0100, then the read-back rewrites it
06 05 3E 00 21 00 01
3C 77 05 C2 07 00
7E 77
// IE = 05, EI, first HALT at 0016
21 FF FF 3E 05 77 FB 76
// DI, IE = 15, second HALT at 001B
F3 3E 15 77 76
// Clear IF, IE back to 05, park in HALT at 0028
21 0F FF 3E 00 77
21 FF FF 3E 05 77 76 C3 28 00
// RETI at each interrupt vector
@40 D9
@48 D9
@50 D9
@58 D9
@60 D9
